// ==== Bender.yml ====
package:
  name: credit_merge

sources:
  # Design, in compile order
  - merge_pkg.sv
  - pkt_stream_if.sv
  - credit_fifo.sv
  - packet_arbiter.sv
  - credit_merge_top.sv

  # Testbench
  - target: simulation
    files:
      - tb_credit_merge.sv

// ==== credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter int DATA_WIDTH = merge_pkg::DEF_DATA_WIDTH,
    parameter int FIFO_DEPTH = merge_pkg::DEF_FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // Producer side
    input  logic [DATA_WIDTH-1:0]       in_data,
    input  logic                        in_last,
    input  logic                        in_valid,
    output logic                        in_ready,

    // Credit side
    input  logic                        credit_return,
    output logic [$clog2(FIFO_DEPTH):0] credits,

    // Stream towards the arbiter
    pkt_stream_if.src                   out_stream
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;

    // Slot storage with payload and packet end flag side by side
    logic [DATA_WIDTH-1:0] mem_data [FIFO_DEPTH];
    logic                  mem_last [FIFO_DEPTH];

    // Pointers carry one extra bit to tell full from empty
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] level;
    logic             full;
    logic             empty;

    logic [PTR_W-1:0] credit_cnt;

    // Registered output stage
    logic [DATA_WIDTH-1:0] out_data_q;
    logic                  out_last_q;
    logic                  out_valid_q;

    logic accept;
    logic out_xfer;
    logic load;

    assign level = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    // Full only at level == depth so every slot is usable
    assign full  = (level == PTR_W'(FIFO_DEPTH));

    // Producer may only push with a credit in hand and room to store it
    // Held low while in reset
    assign in_ready = rst_n && (credit_cnt != '0) && !full;
    assign accept   = in_valid && in_ready;

    assign out_xfer = out_valid_q && out_stream.ready;
    // Refill when the stage is empty or its beat leaves this cycle
    assign load     = !empty && (!out_valid_q || out_xfer);

    assign credits = credit_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (accept) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_data[wr_ptr[ADDR_W-1:0]] <= in_data;
            mem_last[wr_ptr[ADDR_W-1:0]] <= in_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr      <= '0;
            out_valid_q <= 1'b0;
        end else if (load) begin
            rd_ptr      <= rd_ptr + 1'b1;
            out_valid_q <= 1'b1;
        end else if (out_xfer) begin
            out_valid_q <= 1'b0;
        end
    end

    // Payload of the output stage only moves on a load
    always_ff @(posedge clk) begin
        if (load) begin
            out_data_q <= mem_data[rd_ptr[ADDR_W-1:0]];
            out_last_q <= mem_last[rd_ptr[ADDR_W-1:0]];
        end
    end

    // Credit counter
    // Accept takes one and a return gives one back
    // Both at once cancel out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= PTR_W'(FIFO_DEPTH);
        end else begin
            case ({accept, credit_return})
                2'b01: begin
                    // Saturate at the depth so extra returns are dropped
                    if (credit_cnt < PTR_W'(FIFO_DEPTH)) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                2'b10: begin
                    if (credit_cnt != '0) begin
                        credit_cnt <= credit_cnt - 1'b1;
                    end
                end
                default: begin
                    credit_cnt <= credit_cnt;
                end
            endcase
        end
    end

    assign out_stream.data  = out_data_q;
    assign out_stream.last  = out_last_q;
    assign out_stream.valid = out_valid_q;

endmodule

`default_nettype wire

// ==== credit_merge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_merge_top #(
    parameter int DATA_WIDTH = merge_pkg::DEF_DATA_WIDTH,
    parameter int FIFO_DEPTH = merge_pkg::DEF_FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // Channel 0 producer
    input  logic [DATA_WIDTH-1:0]       in0_data,
    input  logic                        in0_last,
    input  logic                        in0_valid,
    output logic                        in0_ready,
    input  logic                        in0_credit_return,
    output logic [$clog2(FIFO_DEPTH):0] in0_credits,

    // Channel 1 producer
    input  logic [DATA_WIDTH-1:0]       in1_data,
    input  logic                        in1_last,
    input  logic                        in1_valid,
    output logic                        in1_ready,
    input  logic                        in1_credit_return,
    output logic [$clog2(FIFO_DEPTH):0] in1_credits,

    // Merged output
    output logic [DATA_WIDTH-1:0]       out_data,
    output logic                        out_last,
    output logic                        out_valid,
    input  logic                        out_ready
);

    pkt_stream_if #(.DATA_WIDTH(DATA_WIDTH)) stream0 ();
    pkt_stream_if #(.DATA_WIDTH(DATA_WIDTH)) stream1 ();

    credit_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_data       (in0_data),
        .in_last       (in0_last),
        .in_valid      (in0_valid),
        .in_ready      (in0_ready),
        .credit_return (in0_credit_return),
        .credits       (in0_credits),
        .out_stream    (stream0.src)
    );

    credit_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo1 (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_data       (in1_data),
        .in_last       (in1_last),
        .in_valid      (in1_valid),
        .in_ready      (in1_ready),
        .credit_return (in1_credit_return),
        .credits       (in1_credits),
        .out_stream    (stream1.src)
    );

    // Channel 0 wins the first grant after reset
    packet_arbiter #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .in0       (stream0.dst),
        .in1       (stream1.dst),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// ==== merge_pkg.sv ====
`default_nettype none

package merge_pkg;

    // Defaults picked up by the top level and handed down
    localparam int DEF_DATA_WIDTH = 8;

    // Also the initial credit count of each input channel
    localparam int DEF_FIFO_DEPTH = 8;

    // Input channels feeding the merger
    localparam int NUM_PORTS = 2;

    // Channel index, wide enough for NUM_PORTS
    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

    // Arbiter states
    // Idle may move its grant, locked holds it until the last beat
    typedef enum logic [0:0] {
        ARB_IDLE   = 1'b0,
        ARB_LOCKED = 1'b1
    } arb_state_t;

endpackage

`default_nettype wire

// ==== packet_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_arbiter #(
    parameter int DATA_WIDTH = merge_pkg::DEF_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Streams from the two input FIFOs
    pkt_stream_if.dst             in0,
    pkt_stream_if.dst             in1,

    // Merged output bus
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_last,
    output logic                  out_valid,
    input  logic                  out_ready
);

    import merge_pkg::*;

    arb_state_t           arbiter_state;
    merge_pkg::port_idx_t grant;
    port_idx_t            other;

    logic [NUM_PORTS-1:0] req;
    logic                 out_xfer;

    assign req   = {in1.valid, in0.valid};
    assign other = ~grant;

    // Output follows the granted stream directly, no extra register
    assign out_valid = req[grant];
    assign out_data  = (grant == port_idx_t'(1)) ? in1.data : in0.data;
    assign out_last  = (grant == port_idx_t'(1)) ? in1.last : in0.last;

    // Only the granted FIFO ever sees ready
    assign in0.ready = out_ready && (grant == port_idx_t'(0));
    assign in1.ready = out_ready && (grant == port_idx_t'(1));

    assign out_xfer = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arbiter_state <= ARB_IDLE;
            grant         <= port_idx_t'(0);
        end else begin
            case (arbiter_state)
                ARB_IDLE: begin
                    if (out_xfer) begin
                        if (out_last) begin
                            // Single beat packet, hand over to the other channel
                            grant <= other;
                        end else begin
                            arbiter_state <= ARB_LOCKED;
                        end
                    end else if (!req[grant] && req[other]) begin
                        // Granted channel has nothing, move to the one waiting
                        grant <= other;
                    end
                end
                ARB_LOCKED: begin
                    // Hold the grant across gaps until the packet is done
                    if (out_xfer && out_last) begin
                        arbiter_state <= ARB_IDLE;
                        grant         <= other;
                    end
                end
                default: begin
                    arbiter_state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== pkt_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pkt_stream_if #(
    parameter int DATA_WIDTH = merge_pkg::DEF_DATA_WIDTH
) ();

    // One beat of a packet
    logic [DATA_WIDTH-1:0] data;
    logic                  last;

    // Handshake, beat moves when both are high on a rising edge
    logic                  valid;
    logic                  ready;

    // Sending side, a FIFO output stage
    modport src (
        output data,
        output last,
        output valid,
        input  ready
    );

    // Receiving side, the arbiter
    modport dst (
        input  data,
        input  last,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// ==== tb.f ====
merge_pkg.sv
pkt_stream_if.sv
credit_fifo.sv
packet_arbiter.sv
credit_merge_top.sv
tb_credit_merge.sv

// ==== tb_credit_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_credit_merge;

    localparam int DATA_WIDTH = 8;
    localparam int FIFO_DEPTH = 8;
    localparam int CNT_W      = $clog2(FIFO_DEPTH) + 1;
    localparam int MAX_BEATS  = 128;
    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_ROWS   = 24;

    // Row phases
    localparam logic [1:0] PH_SEND   = 2'd0;
    localparam logic [1:0] PH_DRAIN  = 2'd1;
    localparam logic [1:0] PH_STARVE = 2'd2;
    localparam logic [1:0] PH_HOLD   = 2'd3;

    // out_ready patterns
    localparam logic [1:0] RDY_ON   = 2'd0;
    localparam logic [1:0] RDY_RAND = 2'd1;
    localparam logic [1:0] RDY_OFF  = 2'd2;

    // ret set means a credit goes back for every beat that leaves
    typedef struct packed {
        logic [1:0] phase;
        logic       ch;
        logic [4:0] len;
        logic [1:0] rdy;
        logic       ret;
    } row_t;

    logic                             clk;
    logic                             rst_n;
    logic [1:0][DATA_WIDTH-1:0]       in_data;
    logic [1:0]                       in_last;
    logic [1:0]                       in_valid;
    logic [1:0]                       in_ready;
    logic [1:0]                       in_credit_return;
    logic [1:0][CNT_W-1:0]            credits;
    logic [DATA_WIDTH-1:0]            out_data;
    logic                             out_last;
    logic                             out_valid;
    logic                             out_ready;

    row_t        rows [NUM_ROWS];
    logic [31:0] lcg_state;
    logic [1:0]  rdy_mode;
    logic        ret_mode;

    // Beats per channel as {last, payload} in the order they are offered
    logic [8:0] tx_mem [2][MAX_BEATS];
    int         gen_cnt [2];
    int         acc_cnt [2];
    int         out_cnt [2];
    int         pkt_in [2];
    int         pkt_out [2];
    int         model [2];
    int         ret_pend [2];
    logic [1:0] acc_flag;

    // Output packet tracking
    logic                  in_pkt;
    int                    pkt_ch;
    int                    expect_ch;
    logic                  hold_prev;
    logic [DATA_WIDTH-1:0] prev_data;
    logic                  prev_last;

    credit_merge_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .in0_data          (in_data[0]),
        .in0_last          (in_last[0]),
        .in0_valid         (in_valid[0]),
        .in0_ready         (in_ready[0]),
        .in0_credit_return (in_credit_return[0]),
        .in0_credits       (credits[0]),
        .in1_data          (in_data[1]),
        .in1_last          (in_last[1]),
        .in1_valid         (in_valid[1]),
        .in1_ready         (in_ready[1]),
        .in1_credit_return (in_credit_return[1]),
        .in1_credits       (credits[1]),
        .out_data          (out_data),
        .out_last          (out_last),
        .out_valid         (out_valid),
        .out_ready         (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_stop();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int exp_val, input int act_val);
        $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp_val, act_val);
        fail_stop();
    endtask

    task automatic report_error(input string msg);
        $display("ERROR time=%0t %s", $time, msg);
        fail_stop();
    endtask

    task automatic load_table();
        rows[0]  = {PH_SEND,   1'b0, 5'd4,  RDY_ON,   1'b1};
        rows[1]  = {PH_SEND,   1'b1, 5'd3,  RDY_ON,   1'b1};
        rows[2]  = {PH_SEND,   1'b0, 5'd1,  RDY_ON,   1'b1};
        rows[3]  = {PH_SEND,   1'b1, 5'd5,  RDY_ON,   1'b1};
        rows[4]  = {PH_DRAIN,  1'b0, 5'd0,  RDY_ON,   1'b1};
        // Stall the sink and let both FIFOs back up
        rows[5]  = {PH_SEND,   1'b0, 5'd6,  RDY_OFF,  1'b1};
        rows[6]  = {PH_SEND,   1'b1, 5'd2,  RDY_OFF,  1'b1};
        rows[7]  = {PH_HOLD,   1'b0, 5'd12, RDY_OFF,  1'b1};
        rows[8]  = {PH_DRAIN,  1'b0, 5'd0,  RDY_RAND, 1'b1};
        // Credits withheld so channel 0 must stop after the depth
        rows[9]  = {PH_SEND,   1'b0, 5'd4,  RDY_ON,   1'b0};
        rows[10] = {PH_SEND,   1'b0, 5'd4,  RDY_ON,   1'b0};
        rows[11] = {PH_SEND,   1'b0, 5'd4,  RDY_ON,   1'b0};
        rows[12] = {PH_STARVE, 1'b0, 5'd10, RDY_ON,   1'b0};
        rows[13] = {PH_DRAIN,  1'b0, 5'd0,  RDY_ON,   1'b1};
        rows[14] = {PH_SEND,   1'b1, 5'd5,  RDY_RAND, 1'b0};
        rows[15] = {PH_SEND,   1'b1, 5'd5,  RDY_RAND, 1'b0};
        rows[16] = {PH_STARVE, 1'b1, 5'd10, RDY_RAND, 1'b0};
        rows[17] = {PH_DRAIN,  1'b0, 5'd0,  RDY_RAND, 1'b1};
        // Both channels waiting so output packets should alternate
        rows[18] = {PH_SEND,   1'b0, 5'd3,  RDY_OFF,  1'b1};
        rows[19] = {PH_SEND,   1'b0, 5'd2,  RDY_OFF,  1'b1};
        rows[20] = {PH_SEND,   1'b1, 5'd3,  RDY_OFF,  1'b1};
        rows[21] = {PH_SEND,   1'b1, 5'd1,  RDY_OFF,  1'b1};
        rows[22] = {PH_HOLD,   1'b0, 5'd6,  RDY_OFF,  1'b1};
        rows[23] = {PH_DRAIN,  1'b0, 5'd0,  RDY_RAND, 1'b1};
    endtask

    // Payload is the channel in bit 7 and a running count below it
    task automatic add_packet(input int ch, input int len);
        for (int b = 0; b < len; b++) begin
            tx_mem[ch][gen_cnt[ch]] = {(b == len - 1), ch[0], gen_cnt[ch][6:0]};
            gen_cnt[ch]++;
        end
    endtask

    function automatic logic drained();
        return out_cnt[0] == gen_cnt[0] && out_cnt[1] == gen_cnt[1] &&
               model[0] == FIFO_DEPTH && model[1] == FIFO_DEPTH;
    endfunction

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_error("timeout waiting for the output to drain and credits to return");
            end
        end while (!drained());
    endtask

    task automatic check_starved(input int ch, input int hold);
        int cycles;
        int held;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_error("timeout waiting for the credits to run out");
            end
        end while (model[ch] != 0);
        held = acc_cnt[ch];
        repeat (hold) @(posedge clk);
        assert (acc_cnt[ch] == held)
            else report_mismatch($sformatf("in%0d accepted beats", ch), held, acc_cnt[ch]);
    endtask

    task automatic check_output_beat();
        int         ch;
        logic [8:0] exp_beat;
        ch = out_data[7];
        assert (out_cnt[ch] < acc_cnt[ch])
            else report_error($sformatf("output beat %0h was never accepted", out_data));
        exp_beat = tx_mem[ch][out_cnt[ch]];
        assert (out_data == exp_beat[7:0])
            else report_mismatch("out_data", exp_beat[7:0], out_data);
        assert (out_last == exp_beat[8]) else report_mismatch("out_last", exp_beat[8], out_last);
        if (in_pkt) begin
            assert (ch == pkt_ch) else report_mismatch("out_data[7]", pkt_ch, ch);
        end else if (expect_ch >= 0) begin
            // A channel that was waiting gets the next packet
            assert (ch == expect_ch) else report_mismatch("out_data[7]", expect_ch, ch);
        end
        out_cnt[ch]++;
        ret_pend[ch]++;
        if (out_last) begin
            in_pkt = 1'b0;
            pkt_out[ch]++;
            expect_ch = (pkt_in[1 - ch] > pkt_out[1 - ch]) ? 1 - ch : -1;
        end else begin
            in_pkt = 1'b1;
            pkt_ch = ch;
        end
    endtask

    // Credit model is depth minus accepts plus returns
    task automatic track_input(input int c);
        logic acc;
        logic ret;
        assert (credits[c] == model[c])
            else report_mismatch($sformatf("in%0d_credits", c), model[c], credits[c]);
        if (model[c] == 0) begin
            assert (!in_ready[c])
                else report_error($sformatf("in%0d_ready is high with no credits left", c));
        end
        acc = in_valid[c] && in_ready[c];
        ret = in_credit_return[c];
        acc_flag[c] = acc;
        if (acc) begin
            if (tx_mem[c][acc_cnt[c]][8]) begin
                pkt_in[c]++;
            end
            acc_cnt[c]++;
        end
        if (acc && !ret) begin
            model[c]--;
        end else if (ret && !acc && model[c] < FIFO_DEPTH) begin
            model[c]++;
        end
    endtask

    // Monitor samples mid-cycle where every signal is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (hold_prev) begin
                assert (out_valid)
                    else report_error("out_valid dropped while out_ready was low");
                assert (out_data == prev_data)
                    else report_mismatch("out_data", prev_data, out_data);
                assert (out_last == prev_last)
                    else report_mismatch("out_last", prev_last, out_last);
            end
            hold_prev = out_valid && !out_ready;
            prev_data = out_data;
            prev_last = out_last;
            if (out_valid && out_ready) begin
                check_output_beat();
            end
            track_input(0);
            track_input(1);
        end
    end

    // Stimulus driver
    always @(posedge clk) begin
        logic [31:0] r;
        if (rst_n) begin
            r = lcg_next();
            case (rdy_mode)
                RDY_ON:   out_ready <= 1'b1;
                RDY_RAND: out_ready <= r[31];
                default:  out_ready <= 1'b0;
            endcase
            for (int c = 0; c < 2; c++) begin
                if (ret_mode && ret_pend[c] > 0) begin
                    in_credit_return[c] <= 1'b1;
                    ret_pend[c] = ret_pend[c] - 1;
                end else begin
                    in_credit_return[c] <= 1'b0;
                end
                // An offered beat stays put until it is taken
                if (!in_valid[c] || acc_flag[c]) begin
                    if (acc_cnt[c] < gen_cnt[c] && r[2*c +: 2] != 2'b00) begin
                        in_valid[c] <= 1'b1;
                        in_data[c]  <= tx_mem[c][acc_cnt[c]][7:0];
                        in_last[c]  <= tx_mem[c][acc_cnt[c]][8];
                    end else begin
                        in_valid[c] <= 1'b0;
                    end
                end
            end
        end
    end

    initial begin
        row_t row;
        lcg_state        = 32'h6334_e269;
        rst_n            = 1'b0;
        in_data          = '0;
        in_last          = '0;
        in_valid         = '0;
        in_credit_return = '0;
        out_ready        = 1'b0;
        rdy_mode         = RDY_ON;
        ret_mode         = 1'b1;
        acc_flag         = '0;
        in_pkt           = 1'b0;
        pkt_ch           = 0;
        expect_ch        = -1;
        hold_prev        = 1'b0;
        prev_data        = '0;
        prev_last        = 1'b0;
        for (int c = 0; c < 2; c++) begin
            gen_cnt[c]     = 0;
            acc_cnt[c]     = 0;
            out_cnt[c]     = 0;
            pkt_in[c]      = 0;
            pkt_out[c]     = 0;
            model[c]       = FIFO_DEPTH;
            ret_pend[c]    = 0;
        end
        load_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (!out_valid) else report_mismatch("out_valid", 0, out_valid);
        assert (!in_ready[0]) else report_mismatch("in0_ready", 0, in_ready[0]);
        assert (!in_ready[1]) else report_mismatch("in1_ready", 0, in_ready[1]);
        @(posedge clk);
        rst_n <= 1'b1;

        // State right after reset
        @(negedge clk);
        assert (credits[0] == FIFO_DEPTH)
            else report_mismatch("in0_credits", FIFO_DEPTH, credits[0]);
        assert (credits[1] == FIFO_DEPTH)
            else report_mismatch("in1_credits", FIFO_DEPTH, credits[1]);
        assert (!out_valid) else report_mismatch("out_valid", 0, out_valid);
        assert (in_ready[0]) else report_mismatch("in0_ready", 1, in_ready[0]);
        assert (in_ready[1]) else report_mismatch("in1_ready", 1, in_ready[1]);

        for (int i = 0; i < NUM_ROWS; i++) begin
            row = rows[i];
            @(negedge clk);
            rdy_mode = row.rdy;
            ret_mode = row.ret;
            case (row.phase)
                PH_SEND:   add_packet(row.ch, row.len);
                PH_DRAIN:  wait_drained();
                PH_STARVE: check_starved(row.ch, row.len);
                default:   repeat (row.len) @(posedge clk);
            endcase
        end

        // No stray beat left inside the DUT once every packet is out
        @(negedge clk);
        assert (!out_valid) else report_mismatch("out_valid", 0, out_valid);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
